/* mem_test_consts.svh */
`ifndef MEM_TEST_CONSTS_SVH
`define MEM_TEST_CONSTS_SVH

// controller address and user data widths.
`define MT_ADDR_WIDTH 27
`define MT_DATA_WIDTH 64

// address window walked by every pass, inclusive at both ends.
`define MT_START_ADDR 27'h0001f00
`define MT_END_ADDR 27'h0002100

// one BL8 burst covers eight column addresses.
`define MT_ADDR_STEP 27'd8

// read-pass counter width.
`define MT_PASS_COUNT_WIDTH 16

// worst case read latency of the controller, in clock cycles.
`define MT_READ_LATENCY_MAX 16

`endif

/* mem_test_pkg.sv */
`include "mem_test_consts.svh"

package mem_test_pkg;

  typedef logic [`MT_ADDR_WIDTH-1:0] app_addr_t;
  typedef logic [`MT_DATA_WIDTH-1:0] app_data_t;
  typedef logic [`MT_PASS_COUNT_WIDTH-1:0] pass_count_t;

  // controller command encoding, only write and read are issued.
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

  typedef enum logic [1:0] {WRITE_CMD, WRITE_DATA, READ_CMD, HALT} seq_phase_e;

  typedef enum logic [1:0] {IDLE, BEAT0, BEAT1} wdata_phase_e;

  typedef struct packed {
    logic      en;
    app_cmd_e  cmd;
    app_addr_t addr;
  } ui_cmd_s;

  typedef struct packed {
    logic      wren;
    logic      last;
    app_data_t data;
  } ui_wdf_s;

  typedef struct packed {
    logic      valid;
    app_data_t data;
  } ui_rd_s;

endpackage

/* mem_test_sequencer.sv */
`timescale 1ns/1ns
`include "mem_test_consts.svh"

module mem_test_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                app_rdy,
  input  logic                burst_done,
  input  logic                error,
  output mem_test_pkg::ui_cmd_s ui_cmd,
  output logic                burst_start
);

  import mem_test_pkg::*;

  localparam app_addr_t START_ADDR = `MT_START_ADDR;
  localparam app_addr_t END_ADDR   = `MT_END_ADDR;
  localparam app_addr_t ADDR_STEP  = `MT_ADDR_STEP;

  seq_phase_e phase;
  logic       en_q;
  app_cmd_e   cmd_q;
  app_addr_t  addr_q;
  logic       last_addr;
  logic       cmd_accept;

  // an error takes the command off the bus in the same cycle it is seen.
  assign ui_cmd = '{en: en_q && !error, cmd: cmd_q, addr: addr_q};

  assign cmd_accept = ui_cmd.en && app_rdy;
  assign last_addr  = (addr_q == END_ADDR);

  // the write generator starts its two beats once the write is taken.
  assign burst_start = cmd_accept && (phase == WRITE_CMD);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase  <= WRITE_CMD;
      en_q   <= 1'b1;
      cmd_q  <= CMD_WRITE;
      addr_q <= START_ADDR;
    end else if (error) begin
      phase <= HALT;
      en_q  <= 1'b0;
    end else begin
      case (phase)
        WRITE_CMD: begin
          if (cmd_accept) begin
            en_q  <= 1'b0;
            phase <= WRITE_DATA;
          end
        end

        WRITE_DATA: begin
          // the address moves on only after both beats are taken.
          if (burst_done) begin
            en_q <= 1'b1;
            if (last_addr) begin
              addr_q <= START_ADDR;
              cmd_q  <= CMD_READ;
              phase  <= READ_CMD;
            end else begin
              addr_q <= addr_q + ADDR_STEP;
              cmd_q  <= CMD_WRITE;
              phase  <= WRITE_CMD;
            end
          end
        end

        READ_CMD: begin
          // reads stream back to back, one per accepted cycle.
          if (cmd_accept) begin
            if (last_addr) begin
              addr_q <= START_ADDR;
              cmd_q  <= CMD_WRITE;
              phase  <= WRITE_CMD;
            end else begin
              addr_q <= addr_q + ADDR_STEP;
            end
          end
        end

        default: begin
          en_q  <= 1'b0;
          phase <= HALT;
        end
      endcase
    end
  end

endmodule

/* mem_test_wdata_gen.sv */
`timescale 1ns/1ns

module mem_test_wdata_gen (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  app_wdf_rdy,
  input  logic                  burst_start,
  output mem_test_pkg::ui_wdf_s ui_wdf,
  output logic                  burst_done
);

  import mem_test_pkg::*;

  wdata_phase_e phase;
  app_data_t    data_q;
  logic         beat_accept;

  // data_q always holds the value of the next beat to send.
  assign ui_wdf = '{wren: (phase != IDLE), last: (phase == BEAT1), data: data_q};

  assign beat_accept = ui_wdf.wren && app_wdf_rdy;
  assign burst_done  = beat_accept && (phase == BEAT1);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= IDLE;
    end else begin
      case (phase)
        IDLE: begin
          if (burst_start) begin
            phase <= BEAT0;
          end
        end
        BEAT0: begin
          if (app_wdf_rdy) begin
            phase <= BEAT1;
          end
        end
        BEAT1: begin
          if (app_wdf_rdy) begin
            phase <= IDLE;
          end
        end
        default: begin
          phase <= IDLE;
        end
      endcase
    end
  end

  // counts across bursts and passes, only reset brings it back to 1.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_q <= app_data_t'(1);
    end else if (beat_accept) begin
      data_q <= data_q + app_data_t'(1);
    end
  end

endmodule

/* mem_test_checker.sv */
`timescale 1ns/1ns
`include "mem_test_consts.svh"

module mem_test_checker (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_test_pkg::ui_rd_s      ui_rd,
  output logic                      error,
  output mem_test_pkg::pass_count_t pass_count
);

  import mem_test_pkg::*;

  // 65 bursts of two beats each make one read pass.
  localparam int BURSTS_PER_PASS = (`MT_END_ADDR - `MT_START_ADDR) / `MT_ADDR_STEP + 1;
  localparam int BEATS_PER_PASS  = 2 * BURSTS_PER_PASS;
  localparam int BEAT_CNT_WIDTH  = $clog2(BEATS_PER_PASS);

  localparam logic [BEAT_CNT_WIDTH-1:0] LAST_BEAT = BEAT_CNT_WIDTH'(BEATS_PER_PASS - 1);

  app_data_t                 expected_q;
  logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
  logic                      match;

  assign match = (ui_rd.data == expected_q);

  // expected data follows the write counter, one step per returned beat.
  always_ff @(posedge clk) begin
    if (reset) begin
      expected_q <= app_data_t'(1);
    end else if (ui_rd.valid) begin
      expected_q <= expected_q + app_data_t'(1);
    end
  end

  // error is sticky, and a failed pass is never counted.
  always_ff @(posedge clk) begin
    if (reset) begin
      error      <= 1'b0;
      beat_cnt   <= '0;
      pass_count <= '0;
    end else if (ui_rd.valid && !error) begin
      if (!match) begin
        error <= 1'b1;
      end else if (beat_cnt == LAST_BEAT) begin
        beat_cnt   <= '0;
        pass_count <= pass_count + pass_count_t'(1);
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

/* mem_test_top.sv */
`timescale 1ns/1ns

module mem_test_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  input  mem_test_pkg::ui_rd_s      ui_rd,
  output mem_test_pkg::ui_cmd_s     ui_cmd,
  output mem_test_pkg::ui_wdf_s     ui_wdf,
  output logic                      error,
  output mem_test_pkg::pass_count_t pass_count
);

  logic burst_start;
  logic burst_done;

  // command side, walks the window and halts on error.
  mem_test_sequencer sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .app_rdy     (app_rdy),
    .burst_done  (burst_done),
    .error       (error),
    .ui_cmd      (ui_cmd),
    .burst_start (burst_start)
  );

  // write data, two beats per burst.
  mem_test_wdata_gen wdata_gen_i (
    .clk         (clk),
    .reset       (reset),
    .app_wdf_rdy (app_wdf_rdy),
    .burst_start (burst_start),
    .ui_wdf      (ui_wdf),
    .burst_done  (burst_done)
  );

  // read data check and pass count.
  mem_test_checker checker_i (
    .clk        (clk),
    .reset      (reset),
    .ui_rd      (ui_rd),
    .error      (error),
    .pass_count (pass_count)
  );

endmodule

/* tb_ui_mem_model.sv */
`timescale 1ns/1ns
`include "mem_test_consts.svh"

module tb_ui_mem_model (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_test_pkg::ui_cmd_s   ui_cmd,
  input  mem_test_pkg::ui_wdf_s   ui_wdf,
  input  logic                    error,
  input  logic [7:0]              cmd_rdy_pct,
  input  logic [7:0]              wdf_rdy_pct,
  input  logic                    fault_en,
  input  mem_test_pkg::app_addr_t fault_addr,
  output logic                    app_rdy,
  output logic                    app_wdf_rdy,
  output mem_test_pkg::ui_rd_s    ui_rd,
  output logic [31:0]             data_errors,
  output logic [31:0]             late_cmds
);

  import mem_test_pkg::*;

  localparam logic [31:0] LAT_MAX    = `MT_READ_LATENCY_MAX;
  localparam app_addr_t   START_ADDR = `MT_START_ADDR;

  typedef struct packed {
    logic [31:0] due;
    app_data_t   data0;
    app_data_t   data1;
  } rd_resp_s;

  // what the DUT showed at the rising edge, handled at the next falling edge.
  typedef struct packed {
    logic    reset_seen;
    logic    error_seen;
    logic    cmd_acc;
    logic    wdf_acc;
    ui_cmd_s cmd;
    ui_wdf_s wdf;
  } edge_snap_s;

  edge_snap_s  snap = '0;
  app_data_t   mem [logic [`MT_ADDR_WIDTH:0]];
  app_addr_t   wr_addr_q [$];
  rd_resp_s    rd_q [$];
  logic [31:0] rnd = 32'hdc4f1da6;
  logic [31:0] cycle = '0;
  logic [31:0] last_due = '0;
  int          read_pass = 0;
  app_data_t   wr_index = app_data_t'(1);
  logic        second_beat = 1'b0;
  logic        cmd_rdy_q = 1'b0;
  logic        wdf_rdy_q = 1'b0;
  ui_rd_s      rd_out_q = '0;
  logic [31:0] data_err_cnt = '0;
  logic [31:0] late_cmd_cnt = '0;

  assign app_rdy     = cmd_rdy_q;
  assign app_wdf_rdy = wdf_rdy_q;
  assign ui_rd       = rd_out_q;
  assign data_errors = data_err_cnt;
  assign late_cmds   = late_cmd_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk) begin
    snap <= '{reset_seen: reset, error_seen: error, cmd_acc: ui_cmd.en && app_rdy,
              wdf_acc: ui_wdf.wren && app_wdf_rdy, cmd: ui_cmd, wdf: ui_wdf};
  end

  always @(negedge clk) begin
    rd_resp_s    resp;
    logic [31:0] due;
    logic [31:0] lat;
    rnd = lcg_next(rnd);
    cmd_rdy_q <= (8'(rnd[31:16] % 16'd100) < cmd_rdy_pct);
    rnd = lcg_next(rnd);
    wdf_rdy_q <= (8'(rnd[31:16] % 16'd100) < wdf_rdy_pct);
    rnd = lcg_next(rnd);
    lat = 32'd1 + ({16'd0, rnd[31:16]} % LAT_MAX);
    if (snap.reset_seen) begin
      cycle       = '0;
      last_due    = '0;
      read_pass   = 0;
      wr_index    = app_data_t'(1);
      second_beat = 1'b0;
      wr_addr_q.delete();
      rd_q.delete();
      rd_out_q <= '0;
    end else begin
      cycle = cycle + 32'd1;
      if (snap.cmd_acc) begin
        if (snap.error_seen) begin
          late_cmd_cnt = late_cmd_cnt + 32'd1;
          $display("%0t ns: command to address %h was accepted after the error flag was set",
                   $time, snap.cmd.addr);
        end
        if (snap.cmd.cmd == CMD_WRITE) begin
          wr_addr_q.push_back(snap.cmd.addr);
        end else begin
          if (snap.cmd.addr == START_ADDR) begin
            read_pass++;
          end
          // read data is taken when the command is accepted, like a real controller.
          resp.data0 = mem[{snap.cmd.addr, 1'b0}];
          resp.data1 = mem[{snap.cmd.addr, 1'b1}];
          if (fault_en && read_pass == 2 && snap.cmd.addr == fault_addr) begin
            resp.data0[0] = ~resp.data0[0];
          end
          // keeps command order and leaves room for both beats.
          due = cycle + lat;
          if (due < last_due + 32'd2) begin
            due = last_due + 32'd2;
          end
          last_due = due;
          resp.due = due;
          rd_q.push_back(resp);
        end
      end
      if (snap.wdf_acc) begin
        if (snap.wdf.data != wr_index) begin
          data_err_cnt = data_err_cnt + 32'd1;
          $display("%0t ns: write beat %0d carried data %h instead of its own index",
                   $time, wr_index, snap.wdf.data);
        end
        if (wr_addr_q.size() == 0) begin
          data_err_cnt = data_err_cnt + 32'd1;
          $display("%0t ns: a write data beat arrived without a write command", $time);
        end else begin
          mem[{wr_addr_q[0], snap.wdf.last}] = snap.wdf.data;
          if (snap.wdf.last) begin
            void'(wr_addr_q.pop_front());
          end
        end
        wr_index = wr_index + app_data_t'(1);
      end
      if (second_beat && rd_q.size() > 0) begin
        rd_out_q <= '{valid: 1'b1, data: rd_q[0].data1};
        void'(rd_q.pop_front());
        second_beat = 1'b0;
      end else if (rd_q.size() > 0 && rd_q[0].due <= cycle) begin
        rd_out_q <= '{valid: 1'b1, data: rd_q[0].data0};
        second_beat = 1'b1;
      end else begin
        rd_out_q <= '0;
      end
    end
  end

endmodule

/* tb_mem_test_assertions.sv */
`timescale 1ns/1ns

module tb_mem_test_assertions (
  input logic                  clk,
  input logic                  reset,
  input logic                  app_rdy,
  input logic                  app_wdf_rdy,
  input mem_test_pkg::ui_cmd_s ui_cmd,
  input mem_test_pkg::ui_wdf_s ui_wdf,
  input logic                  error
);

  int unsigned cmd_fails = 0;
  int unsigned wdf_fails = 0;
  int unsigned err_fails = 0;

  // a waiting command keeps en, cmd and addr.
  cmd_hold: assert property (@(posedge clk) disable iff (reset || error)
    (ui_cmd.en && !app_rdy) |=> (ui_cmd.en && $stable(ui_cmd)))
    else begin
      $error("command changed while it waited for app_rdy");
      cmd_fails++;
    end

  wdf_hold: assert property (@(posedge clk) disable iff (reset)
    (ui_wdf.wren && !app_wdf_rdy) |=> (ui_wdf.wren && $stable(ui_wdf)))
    else begin
      $error("write data changed while it waited for app_wdf_rdy");
      wdf_fails++;
    end

  // only reset may clear the error flag.
  err_sticky: assert property (@(posedge clk) disable iff (reset)
    error |=> error)
    else begin
      $error("error flag fell without a reset");
      err_fails++;
    end

endmodule

bind mem_test_top tb_mem_test_assertions assertions_i (
  .clk         (clk),
  .reset       (reset),
  .app_rdy     (app_rdy),
  .app_wdf_rdy (app_wdf_rdy),
  .ui_cmd      (ui_cmd),
  .ui_wdf      (ui_wdf),
  .error       (error)
);

/* tb_mem_test.sv */
`timescale 1ns/1ns
`include "mem_test_consts.svh"

module tb_mem_test;

  import mem_test_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ROWS     = 5;

  // command shown on the bus right after reset.
  localparam ui_cmd_s RESET_CMD = '{en: 1'b1, cmd: CMD_WRITE, addr: `MT_START_ADDR};

  typedef struct packed {
    logic [7:0]  cmd_pct;
    logic [7:0]  wdf_pct;
    logic [31:0] cycles;
    logic        fault_en;
    app_addr_t   fault_addr;
    logic        exp_error;
    pass_count_t min_pass;
    pass_count_t max_pass;
  } scenario_s;

  scenario_s   scenarios [NUM_ROWS];
  logic        table_loaded = 1'b0;
  int unsigned check_errors = 0;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        app_rdy;
  logic        app_wdf_rdy;
  ui_rd_s      ui_rd;
  ui_cmd_s     ui_cmd;
  ui_wdf_s     ui_wdf;
  logic        error;
  pass_count_t pass_count;

  logic [7:0]  cmd_pct = 8'd100;
  logic [7:0]  wdf_pct = 8'd100;
  logic        fault_en = 1'b0;
  app_addr_t   fault_addr = '0;
  logic [31:0] data_errors;
  logic [31:0] late_cmds;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mem_test_top mem_test_top_i (
    .clk         (clk),
    .reset       (reset),
    .app_rdy     (app_rdy),
    .app_wdf_rdy (app_wdf_rdy),
    .ui_rd       (ui_rd),
    .ui_cmd      (ui_cmd),
    .ui_wdf      (ui_wdf),
    .error       (error),
    .pass_count  (pass_count)
  );

  tb_ui_mem_model mem_model_i (
    .clk         (clk),
    .reset       (reset),
    .ui_cmd      (ui_cmd),
    .ui_wdf      (ui_wdf),
    .error       (error),
    .cmd_rdy_pct (cmd_pct),
    .wdf_rdy_pct (wdf_pct),
    .fault_en    (fault_en),
    .fault_addr  (fault_addr),
    .app_rdy     (app_rdy),
    .app_wdf_rdy (app_wdf_rdy),
    .ui_rd       (ui_rd),
    .data_errors (data_errors),
    .late_cmds   (late_cmds)
  );

  task automatic load_scenarios();
    // a clean pass takes about 260 cycles at full speed.
    scenarios[0] = '{8'd100, 8'd100, 32'd1200, 1'b0, 27'h0, 1'b0, 16'd3, 16'hffff};
    // half the cycles stall, so the run is made about twice as long.
    scenarios[1] = '{8'd50, 8'd50, 32'd3000, 1'b0, 27'h0, 1'b0, 16'd3, 16'hffff};
    scenarios[2] = '{8'd100, 8'd100, 32'd1200, 1'b1, 27'h0002000, 1'b1, 16'd1, 16'd1};
    scenarios[3] = '{8'd60, 8'd40, 32'd3000, 1'b1, 27'h0001f00, 1'b1, 16'd1, 16'd1};
    scenarios[4] = '{8'd70, 8'd90, 32'd2000, 1'b0, 27'h0, 1'b0, 16'd2, 16'hffff};
  endtask

  function automatic longint unsigned run_time_limit();
    longint unsigned cycles;
    cycles = 0;
    for (int row = 0; row < NUM_ROWS; row++) begin
      cycles += 64'(scenarios[row].cycles) + 64'(RESET_CYCLES + 1);
    end
    return cycles * 64'(2 * CLK_PERIOD);
  endfunction

  task automatic apply_reset(input int row);
    @(negedge clk);
    reset      = 1'b1;
    cmd_pct    = scenarios[row].cmd_pct;
    wdf_pct    = scenarios[row].wdf_pct;
    fault_en   = scenarios[row].fault_en;
    fault_addr = scenarios[row].fault_addr;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_error(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      check_errors++;
      $display("[ERROR] %0t ns: %s error is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_pass_count(input pass_count_t actual, input pass_count_t min_count,
                                  input pass_count_t max_count, input string what);
    if ($isunknown(actual) || actual < min_count || actual > max_count) begin
      check_errors++;
      $display("[ERROR] %0t ns: %s pass_count is %0d, expected %0d to %0d",
               $time, what, actual, min_count, max_count);
    end
  endtask

  task automatic check_cmd(input ui_cmd_s actual, input ui_cmd_s expected, input string what);
    if (actual !== expected) begin
      check_errors++;
      $display("[ERROR] %0t ns: %s command is en %b cmd %0d addr %h, expected %b %0d %h",
               $time, what, actual.en, actual.cmd, actual.addr,
               expected.en, expected.cmd, expected.addr);
    end
  endtask

  task automatic check_wdf(input ui_wdf_s actual, input logic exp_wren, input string what);
    if (actual.wren !== exp_wren) begin
      check_errors++;
      $display("[ERROR] %0t ns: %s wren is %b, expected %b",
               $time, what, actual.wren, exp_wren);
    end
  endtask

  initial begin
    int unsigned total;
    load_scenarios();
    table_loaded = 1'b1;
    for (int row = 0; row < NUM_ROWS; row++) begin
      apply_reset(row);
      check_error(error, 1'b0, $sformatf("row %0d after reset,", row));
      check_pass_count(pass_count, '0, '0, $sformatf("row %0d after reset,", row));
      check_cmd(ui_cmd, RESET_CMD, $sformatf("row %0d after reset,", row));
      check_wdf(ui_wdf, 1'b0, $sformatf("row %0d after reset,", row));
      repeat (scenarios[row].cycles) @(negedge clk);
      check_error(error, scenarios[row].exp_error, $sformatf("row %0d at end,", row));
      check_pass_count(pass_count, scenarios[row].min_pass, scenarios[row].max_pass,
                       $sformatf("row %0d at end,", row));
    end
    total = check_errors + data_errors + late_cmds + mem_test_top_i.assertions_i.cmd_fails +
            mem_test_top_i.assertions_i.wdf_fails + mem_test_top_i.assertions_i.err_fails;
    $display("%0d rows run, %0d check errors, %0d write data errors, %0d late commands, %0d %s",
             NUM_ROWS, check_errors, data_errors, late_cmds,
             total - check_errors - data_errors - late_cmds, "assertion failures");
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    longint unsigned limit;
    wait (table_loaded);
    limit = run_time_limit();
    #(limit);
    $display("watchdog expired after %0d ns before all scenarios finished", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
mem_test_pkg.sv
mem_test_sequencer.sv
mem_test_wdata_gen.sv
mem_test_checker.sv
mem_test_top.sv
tb_ui_mem_model.sv
tb_mem_test_assertions.sv
tb_mem_test.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_mem_test
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUNFLAGS  := +verilator+error+limit+100
SRCS      := $(shell grep -v '^+' $(FILELIST)) mem_test_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
